/* exec_pkg.sv */
package exec_pkg;

  localparam int XLEN       = 32;
  localparam int REG_W      = 5;
  localparam int CB_INDEX_W = 3;
  localparam int MUL_STAGES = 3;
  localparam int DIV_CYCLES = 32;
  localparam int DIV_CNT_W  = $clog2(DIV_CYCLES);

  typedef enum logic [4:0] {
    OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
    OP_SLL, OP_SRL, OP_SRA, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JAL,
    OP_JALR, OP_MUL, OP_MULHU, OP_DIVU, OP_REMU
  } exec_op_e;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

  // One issued instruction with its operands
  typedef struct packed {
    logic                  valid;
    exec_op_e              op;
    logic [REG_W-1:0]      rd;
    logic [CB_INDEX_W-1:0] index;
    logic [XLEN-1:0]       rs1;
    logic [XLEN-1:0]       rs2;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
  } exec_issue_t;

  // Register writeback toward the completion buffer
  typedef struct packed {
    logic                  valid;
    logic [REG_W-1:0]      rd;
    logic [CB_INDEX_W-1:0] index;
    logic [XLEN-1:0]       data;
  } wb_result_t;

  typedef struct packed {
    logic            is_branch;
    logic            is_jump;
    logic            taken;
    logic [XLEN-1:0] resolved_addr;
  } ctrl_flow_t;

  typedef struct packed {
    wb_result_t arith;
    wb_result_t mul;
    wb_result_t div;
    ctrl_flow_t flow;
  } commit_bundle_t;

endpackage

/* alu_branch_unit.sv */
`timescale 1ns/1ps

module alu_branch_unit (
  input  exec_pkg::exec_issue_t issue,
  output exec_pkg::wb_result_t  arith,
  output exec_pkg::ctrl_flow_t  flow
);

  logic [exec_pkg::XLEN-1:0] alu_out;
  logic [exec_pkg::XLEN-1:0] pc_plus4;
  logic [exec_pkg::XLEN-1:0] pc_plus_imm;
  logic [exec_pkg::XLEN-1:0] jalr_sum;
  logic [4:0]                shamt;
  logic                      writes_rd;
  logic                      cond;
  logic                      is_branch;
  logic                      is_jump;

  assign shamt       = issue.rs2[4:0];
  assign pc_plus4    = issue.pc + (exec_pkg::XLEN)'(4);
  assign pc_plus_imm = issue.pc + issue.imm;
  assign jalr_sum    = issue.rs1 + issue.imm;

  // Register result, jumps write the link address
  always_comb begin
    alu_out   = '0;
    writes_rd = 1'b1;
    case (issue.op)
      exec_pkg::OP_ADD:  alu_out = issue.rs1 + issue.rs2;
      exec_pkg::OP_SUB:  alu_out = issue.rs1 - issue.rs2;
      exec_pkg::OP_AND:  alu_out = issue.rs1 & issue.rs2;
      exec_pkg::OP_OR:   alu_out = issue.rs1 | issue.rs2;
      exec_pkg::OP_XOR:  alu_out = issue.rs1 ^ issue.rs2;
      exec_pkg::OP_SLT:  alu_out[0] = $signed(issue.rs1) < $signed(issue.rs2);
      exec_pkg::OP_SLTU: alu_out[0] = issue.rs1 < issue.rs2;
      exec_pkg::OP_SLL:  alu_out = issue.rs1 << shamt;
      exec_pkg::OP_SRL:  alu_out = issue.rs1 >> shamt;
      exec_pkg::OP_SRA:  alu_out = $signed(issue.rs1) >>> shamt;
      exec_pkg::OP_JAL,
      exec_pkg::OP_JALR: alu_out = pc_plus4;
      default:           writes_rd = 1'b0;
    endcase
  end

  // Branch comparison, blt and bge are signed
  always_comb begin
    case (issue.op)
      exec_pkg::OP_BEQ: cond = issue.rs1 == issue.rs2;
      exec_pkg::OP_BNE: cond = issue.rs1 != issue.rs2;
      exec_pkg::OP_BLT: cond = $signed(issue.rs1) < $signed(issue.rs2);
      exec_pkg::OP_BGE: cond = $signed(issue.rs1) >= $signed(issue.rs2);
      default:          cond = 1'b0;
    endcase
  end

  assign is_branch = issue.valid && (issue.op inside {exec_pkg::OP_BEQ, exec_pkg::OP_BNE,
                                                      exec_pkg::OP_BLT, exec_pkg::OP_BGE});
  assign is_jump   = issue.valid && (issue.op inside {exec_pkg::OP_JAL, exec_pkg::OP_JALR});

  assign arith.valid = issue.valid & writes_rd;
  assign arith.rd    = issue.rd;
  assign arith.index = issue.index;
  assign arith.data  = alu_out;

  assign flow.is_branch = is_branch;
  assign flow.is_jump   = is_jump;
  assign flow.taken     = is_jump | (is_branch & cond);

  // jalr target has bit 0 forced low
  always_comb begin
    if (issue.op == exec_pkg::OP_JALR) begin
      flow.resolved_addr = {jalr_sum[exec_pkg::XLEN-1:1], 1'b0};
    end else if (issue.op == exec_pkg::OP_JAL || cond) begin
      flow.resolved_addr = pc_plus_imm;
    end else begin
      flow.resolved_addr = pc_plus4;
    end
  end

endmodule

/* mul_pipe.sv */
`timescale 1ns/1ps

module mul_pipe (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  in_valid,
  input  exec_pkg::exec_issue_t issue,
  input  logic                  hold,
  input  logic                  clear,
  output exec_pkg::wb_result_t  result
);

  logic [exec_pkg::MUL_STAGES-1:0] vld;
  logic [exec_pkg::REG_W-1:0]      rd_q  [exec_pkg::MUL_STAGES];
  logic [exec_pkg::CB_INDEX_W-1:0] idx_q [exec_pkg::MUL_STAGES];

  logic [exec_pkg::XLEN-1:0]   op_a;
  logic [exec_pkg::XLEN-1:0]   op_b;
  logic                        hi_s1;
  logic                        hi_s2;
  logic [2*exec_pkg::XLEN-1:0] prod;
  logic [exec_pkg::XLEN-1:0]   data_q;

  // Valid bits are the only control state
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vld <= '0;
    end else if (clear) begin
      vld <= '0;
    end else if (!hold) begin
      vld <= {vld[exec_pkg::MUL_STAGES-2:0], in_valid};
    end
  end

  // rd and index ride alongside the data
  always_ff @(posedge CLK) begin
    if (!hold) begin
      rd_q[0]  <= issue.rd;
      idx_q[0] <= issue.index;
      for (int i = 1; i < exec_pkg::MUL_STAGES; i++) begin
        rd_q[i]  <= rd_q[i-1];
        idx_q[i] <= idx_q[i-1];
      end
    end
  end

  // Operands, full product, then word select
  always_ff @(posedge CLK) begin
    if (!hold) begin
      op_a   <= issue.rs1;
      op_b   <= issue.rs2;
      hi_s1  <= issue.op == exec_pkg::OP_MULHU;
      prod   <= {{exec_pkg::XLEN{1'b0}}, op_a} * {{exec_pkg::XLEN{1'b0}}, op_b};
      hi_s2  <= hi_s1;
      data_q <= hi_s2 ? prod[2*exec_pkg::XLEN-1:exec_pkg::XLEN] : prod[exec_pkg::XLEN-1:0];
    end
  end

  assign result.valid = vld[exec_pkg::MUL_STAGES-1];
  assign result.rd    = rd_q[exec_pkg::MUL_STAGES-1];
  assign result.index = idx_q[exec_pkg::MUL_STAGES-1];
  assign result.data  = data_q;

endmodule

/* div_ctrl_fsm.sv */
`timescale 1ns/1ps

module div_ctrl_fsm (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 start,
  input  logic                 hold,
  input  logic                 clear,
  input  logic                 last_iter,
  output exec_pkg::div_state_e state,
  output logic                 busy
);

  exec_pkg::div_state_e next_state;

  always_comb begin
    next_state = state;
    case (state)
      exec_pkg::DIV_IDLE: if (start) next_state = exec_pkg::DIV_RUN;
      exec_pkg::DIV_RUN:  if (last_iter) next_state = exec_pkg::DIV_DONE;
      // Result is offered for a single cycle
      exec_pkg::DIV_DONE: next_state = exec_pkg::DIV_IDLE;
      default:            next_state = exec_pkg::DIV_IDLE;
    endcase
  end

  // Flush aborts even while the commit side is stalled
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= exec_pkg::DIV_IDLE;
    end else if (clear) begin
      state <= exec_pkg::DIV_IDLE;
    end else if (!hold) begin
      state <= next_state;
    end
  end

  assign busy = state != exec_pkg::DIV_IDLE;

endmodule

/* div_iter_counter.sv */
`timescale 1ns/1ps

module div_iter_counter (
  input  logic                 CLK,
  input  logic                 nRST,
  input  exec_pkg::div_state_e state,
  input  logic                 hold,
  output logic                 last_iter
);

  logic [exec_pkg::DIV_CNT_W-1:0] count;

  // Restarts from zero whenever the divider leaves the run state
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (state != exec_pkg::DIV_RUN) begin
      count <= '0;
    end else if (!hold) begin
      count <= count + (exec_pkg::DIV_CNT_W)'(1);
    end
  end

  assign last_iter = (state == exec_pkg::DIV_RUN) &&
                     (count == (exec_pkg::DIV_CNT_W)'(exec_pkg::DIV_CYCLES - 1));

endmodule

/* div_datapath.sv */
`timescale 1ns/1ps

module div_datapath (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  start,
  input  exec_pkg::exec_issue_t issue,
  input  exec_pkg::div_state_e  state,
  input  logic                  hold,
  output exec_pkg::wb_result_t  result
);

  logic [exec_pkg::XLEN-1:0]       rem_q;
  logic [exec_pkg::XLEN-1:0]       quo_q;
  logic [exec_pkg::XLEN-1:0]       divisor_q;
  logic [exec_pkg::REG_W-1:0]      rd_q;
  logic [exec_pkg::CB_INDEX_W-1:0] idx_q;
  logic                            rem_sel;

  logic [exec_pkg::XLEN:0] shifted;
  logic [exec_pkg::XLEN:0] diff;
  logic                    fits;

  // One restoring step, next dividend bit shifts in from the quotient register
  assign shifted = {rem_q, quo_q[exec_pkg::XLEN-1]};
  assign diff    = shifted - {1'b0, divisor_q};
  assign fits    = shifted >= {1'b0, divisor_q};

  // A zero divisor always fits, which leaves an all-ones quotient
  // and the dividend as remainder after the last step
  always_ff @(posedge CLK) begin
    if (start) begin
      rem_q     <= '0;
      quo_q     <= issue.rs1;
      divisor_q <= issue.rs2;
    end else if (state == exec_pkg::DIV_RUN && !hold) begin
      rem_q <= fits ? diff[exec_pkg::XLEN-1:0] : shifted[exec_pkg::XLEN-1:0];
      quo_q <= {quo_q[exec_pkg::XLEN-2:0], fits};
    end
  end

  // Tag of the divide in progress
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rd_q    <= '0;
      idx_q   <= '0;
      rem_sel <= 1'b0;
    end else if (start) begin
      rd_q    <= issue.rd;
      idx_q   <= issue.index;
      rem_sel <= issue.op == exec_pkg::OP_REMU;
    end
  end

  assign result.valid = state == exec_pkg::DIV_DONE;
  assign result.rd    = rd_q;
  assign result.index = idx_q;
  assign result.data  = rem_sel ? rem_q : quo_q;

endmodule

/* commit_latch.sv */
`timescale 1ns/1ps

module commit_latch (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     flush,
  input  logic                     stall_commit,
  input  exec_pkg::wb_result_t     arith,
  input  exec_pkg::ctrl_flow_t     flow,
  input  exec_pkg::wb_result_t     mul,
  input  exec_pkg::wb_result_t     div,
  output exec_pkg::commit_bundle_t commit
);

  // Flush wins over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      commit <= '0;
    end else if (flush) begin
      commit <= '0;
    end else if (!stall_commit) begin
      commit.arith <= arith;
      commit.mul   <= mul;
      commit.div   <= div;
      commit.flow  <= flow;
    end
  end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  exec_pkg::exec_issue_t    issue,
  output logic                     issue_ready,
  input  logic                     flush,
  input  logic                     stall_commit,
  output exec_pkg::commit_bundle_t commit,
  output logic                     div_busy
);

  exec_pkg::wb_result_t arith_raw;
  exec_pkg::wb_result_t arith;
  exec_pkg::ctrl_flow_t flow_raw;
  exec_pkg::ctrl_flow_t flow;
  exec_pkg::wb_result_t mul_res;
  exec_pkg::wb_result_t div_res;
  exec_pkg::div_state_e div_state;

  logic accept;
  logic is_mul;
  logic is_div;
  logic mul_start;
  logic div_start;
  logic last_iter;

  assign is_mul = issue.op inside {exec_pkg::OP_MUL, exec_pkg::OP_MULHU};
  assign is_div = issue.op inside {exec_pkg::OP_DIVU, exec_pkg::OP_REMU};

  // Only one divide in flight
  assign issue_ready = !stall_commit && !(div_busy && is_div);
  assign accept      = issue.valid && issue_ready;
  assign mul_start   = accept && is_mul;
  assign div_start   = accept && is_div;

  // Single-cycle results count only for accepted issues
  always_comb begin
    arith           = arith_raw;
    arith.valid     = arith_raw.valid & accept;
    flow            = flow_raw;
    flow.is_branch  = flow_raw.is_branch & accept;
    flow.is_jump    = flow_raw.is_jump & accept;
    flow.taken      = flow_raw.taken & accept;
  end

  alu_branch_unit alu_branch_unit_inst (
    .issue (issue),
    .arith (arith_raw),
    .flow  (flow_raw)
  );

  mul_pipe mul_pipe_inst (
    .CLK      (CLK),
    .nRST     (nRST),
    .in_valid (mul_start),
    .issue    (issue),
    .hold     (stall_commit),
    .clear    (flush),
    .result   (mul_res)
  );

  div_ctrl_fsm div_ctrl_fsm_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (div_start),
    .hold      (stall_commit),
    .clear     (flush),
    .last_iter (last_iter),
    .state     (div_state),
    .busy      (div_busy)
  );

  div_iter_counter div_iter_counter_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .state     (div_state),
    .hold      (stall_commit),
    .last_iter (last_iter)
  );

  div_datapath div_datapath_inst (
    .CLK    (CLK),
    .nRST   (nRST),
    .start  (div_start),
    .issue  (issue),
    .state  (div_state),
    .hold   (stall_commit),
    .result (div_res)
  );

  commit_latch commit_latch_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .flush        (flush),
    .stall_commit (stall_commit),
    .arith        (arith),
    .flow         (flow),
    .mul          (mul_res),
    .div          (div_res),
    .commit       (commit)
  );

endmodule

/* execute_stage_props.sv */
`timescale 1ns/1ps

module execute_stage_props (
  input logic                     CLK,
  input logic                     nRST,
  input exec_pkg::exec_issue_t    issue,
  input logic                     issue_ready,
  input logic                     flush,
  input logic                     stall_commit,
  input exec_pkg::commit_bundle_t commit,
  input logic                     div_busy
);

  logic any_valid;

  assign any_valid = commit.arith.valid || commit.mul.valid || commit.div.valid ||
                     commit.flow.is_branch || commit.flow.is_jump;

  reset_clean: assert property (@(posedge CLK) $rose(nRST) |-> !any_valid && !div_busy)
    else $error("commit valid or divider busy right after reset release");

  flush_clears: assert property (@(posedge CLK) disable iff (!nRST) flush |=> !any_valid)
    else $error("commit valid one edge after flush");

  // Frozen latch while the commit side stalls
  stall_holds: assert property (@(posedge CLK) disable iff (!nRST)
    stall_commit && !flush |=> $stable(commit))
    else $error("commit changed across a stalled edge");

  one_divide: assert property (@(posedge CLK) disable iff (!nRST)
    div_busy && issue.valid && (issue.op inside {exec_pkg::OP_DIVU, exec_pkg::OP_REMU})
    |-> !issue_ready)
    else $error("divide offered while divider busy was accepted");

endmodule

bind execute_stage execute_stage_props execute_stage_props_inst (
  .CLK          (CLK),
  .nRST         (nRST),
  .issue        (issue),
  .issue_ready  (issue_ready),
  .flush        (flush),
  .stall_commit (stall_commit),
  .commit       (commit),
  .div_busy     (div_busy)
);

/* tb_execute_stage.sv */
`timescale 1ns/1ps

module tb_execute_stage;

  localparam int N_RANDOM    = 200;
  localparam int N_DIRECTED  = 46;
  localparam int CYCLE_LIMIT = 40 * (N_RANDOM + N_DIRECTED) + 200;
  localparam int CMP_W       = $bits(exec_pkg::commit_bundle_t);

  logic                     CLK          = 1'b0;
  logic                     nRST         = 1'b0;
  logic                     flush        = 1'b0;
  logic                     stall_commit = 1'b0;
  exec_pkg::exec_issue_t    issue        = '0;
  logic                     issue_ready;
  logic                     div_busy;
  exec_pkg::commit_bundle_t commit;
  exec_pkg::commit_bundle_t last_commit;

  // Expected results per commit channel
  exec_pkg::wb_result_t arith_q[$];
  exec_pkg::wb_result_t mul_q[$];
  exec_pkg::wb_result_t div_q[$];
  exec_pkg::ctrl_flow_t flow_q[$];
  int                   mul_due_q[$];

  logic [31:0] seed       = 32'he08;
  logic        was_flush  = 1'b0;
  logic        was_stall  = 1'b0;
  int          errors     = 0;
  int          cyc        = 0;
  int          held_edges = 0;
  int          n_issued   = 0;

  always #4 CLK = ~CLK;

  execute_stage execute_stage_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .issue        (issue),
    .issue_ready  (issue_ready),
    .flush        (flush),
    .stall_commit (stall_commit),
    .commit       (commit),
    .div_busy     (div_busy)
  );

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Corner values mixed with random words
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = lcg_next();
    case (r[18:16])
      3'd0:    return 32'd0;
      3'd1:    return 32'd31;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'hffff_fff0;
      default: return lcg_next();
    endcase
  endfunction

  task automatic check_value(input string name, input logic [CMP_W-1:0] exp_v,
                             input logic [CMP_W-1:0] act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
    end
  endtask

  // Reference results straight from the RV32 rules
  function automatic void exec_model(input exec_pkg::exec_issue_t req,
                                     output exec_pkg::wb_result_t wb,
                                     output exec_pkg::ctrl_flow_t fl);
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] prod;
    a = req.rs1;
    b = req.rs2;
    prod = {32'b0, a} * {32'b0, b};
    wb = '0;
    fl = '0;
    wb.rd = req.rd;
    wb.index = req.index;
    fl.is_branch = req.op inside {exec_pkg::OP_BEQ, exec_pkg::OP_BNE,
                                  exec_pkg::OP_BLT, exec_pkg::OP_BGE};
    fl.is_jump = req.op inside {exec_pkg::OP_JAL, exec_pkg::OP_JALR};
    fl.taken = fl.is_jump;
    wb.valid = !fl.is_branch;
    case (req.op)
      exec_pkg::OP_ADD:   wb.data = a + b;
      exec_pkg::OP_SUB:   wb.data = a - b;
      exec_pkg::OP_AND:   wb.data = a & b;
      exec_pkg::OP_OR:    wb.data = a | b;
      exec_pkg::OP_XOR:   wb.data = a ^ b;
      exec_pkg::OP_SLT:   wb.data = {31'b0, $signed(a) < $signed(b)};
      exec_pkg::OP_SLTU:  wb.data = {31'b0, a < b};
      exec_pkg::OP_SLL:   wb.data = a << b[4:0];
      exec_pkg::OP_SRL:   wb.data = a >> b[4:0];
      exec_pkg::OP_SRA:   wb.data = $signed(a) >>> b[4:0];
      exec_pkg::OP_BEQ:   fl.taken = a == b;
      exec_pkg::OP_BNE:   fl.taken = a != b;
      exec_pkg::OP_BLT:   fl.taken = $signed(a) < $signed(b);
      exec_pkg::OP_BGE:   fl.taken = $signed(a) >= $signed(b);
      exec_pkg::OP_JAL,
      exec_pkg::OP_JALR:  wb.data = req.pc + 32'd4;
      exec_pkg::OP_MUL:   wb.data = prod[31:0];
      exec_pkg::OP_MULHU: wb.data = prod[63:32];
      exec_pkg::OP_DIVU:  wb.data = (b == 32'd0) ? 32'hffff_ffff : a / b;
      exec_pkg::OP_REMU:  wb.data = (b == 32'd0) ? a : a % b;
      default:            wb.valid = 1'b0;
    endcase
    if (req.op == exec_pkg::OP_JALR) begin
      fl.resolved_addr = (a + req.imm) & 32'hffff_fffe;
    end else if (fl.taken) begin
      fl.resolved_addr = req.pc + req.imm;
    end else begin
      fl.resolved_addr = req.pc + 32'd4;
    end
  endfunction

  // Offer one op until it is taken, starting and ending 1 ns after an edge
  task automatic send(input exec_pkg::exec_op_e op, input logic [31:0] rs1,
                      input logic [31:0] rs2, input logic [31:0] imm);
    exec_pkg::wb_result_t wb;
    exec_pkg::ctrl_flow_t fl;
    logic [31:0]          r;
    logic                 done;
    r = lcg_next();
    done = 1'b0;
    issue.valid = 1'b1;
    issue.op = op;
    issue.rd = r[20:16];
    issue.index = r[23:21];
    issue.rs1 = rs1;
    issue.rs2 = rs2;
    issue.imm = imm;
    issue.pc = {16'h0, r[15:2], 2'b00};
    while (!done) begin
      @(negedge CLK);
      if (issue_ready) begin
        done = 1'b1;
      end else begin
        @(posedge CLK);
        #1;
      end
    end
    exec_model(issue, wb, fl);
    n_issued++;
    if (op inside {exec_pkg::OP_MUL, exec_pkg::OP_MULHU}) begin
      mul_q.push_back(wb);
      mul_due_q.push_back(cyc + 1 + exec_pkg::MUL_STAGES - held_edges);
    end else if (op inside {exec_pkg::OP_DIVU, exec_pkg::OP_REMU}) begin
      // Only an idle divider may take a new divide
      check_value("div_busy", '0, (CMP_W)'(div_busy));
      div_q.push_back(wb);
    end else begin
      if (wb.valid) begin
        arith_q.push_back(wb);
      end
      if (fl.is_branch || fl.is_jump) begin
        flow_q.push_back(fl);
      end
    end
    @(posedge CLK);
    #1;
    issue.valid = 1'b0;
  endtask

  task automatic hold_commit(input int n);
    stall_commit = 1'b1;
    repeat (n) @(posedge CLK);
    #1;
    stall_commit = 1'b0;
  endtask

  // Everything in flight is dropped by the DUT
  task automatic flush_pipe();
    flush = 1'b1;
    @(posedge CLK);
    #1;
    flush = 1'b0;
    arith_q.delete();
    mul_q.delete();
    mul_due_q.delete();
    div_q.delete();
    flow_q.delete();
  endtask

  always @(posedge CLK) begin
    cyc++;
    if (cyc >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with %0d results still outstanding", cyc,
               arith_q.size() + mul_q.size() + div_q.size() + flow_q.size());
      $display("%0d ops issued, %0d errors", n_issued, errors);
      $display("Test failed");
      $finish;
    end
  end

  // Scoreboard, looks at what the last edge put on commit
  always @(negedge CLK) begin : compare
    exec_pkg::wb_result_t exp_wb;
    exec_pkg::ctrl_flow_t exp_fl;
    if (nRST && was_flush) begin
      check_value("commit valids after flush", '0,
                  (CMP_W)'({commit.arith.valid, commit.mul.valid, commit.div.valid,
                            commit.flow.is_branch, commit.flow.is_jump}));
    end else if (nRST && was_stall) begin
      check_value("commit under stall", last_commit, commit);
    end else if (nRST) begin
      if (commit.arith.valid && arith_q.size() == 0) begin
        errors++;
        $display("%0t: arith result committed with none expected", $time);
      end else if (commit.arith.valid) begin
        exp_wb = arith_q.pop_front();
        check_value("commit.arith", (CMP_W)'(exp_wb), (CMP_W)'(commit.arith));
      end
      if ((commit.flow.is_branch || commit.flow.is_jump) && flow_q.size() == 0) begin
        errors++;
        $display("%0t: branch or jump committed with none expected", $time);
      end else if (commit.flow.is_branch || commit.flow.is_jump) begin
        exp_fl = flow_q.pop_front();
        check_value("commit.flow", (CMP_W)'(exp_fl), (CMP_W)'(commit.flow));
      end
      if (commit.mul.valid && mul_q.size() == 0) begin
        errors++;
        $display("%0t: mul result committed with none expected", $time);
      end else if (commit.mul.valid) begin
        exp_wb = mul_q.pop_front();
        check_value("commit.mul", (CMP_W)'(exp_wb), (CMP_W)'(commit.mul));
        check_value("mul latency", (CMP_W)'(mul_due_q.pop_front() + held_edges),
                    (CMP_W)'(cyc));
      end
      if (commit.div.valid && div_q.size() == 0) begin
        errors++;
        $display("%0t: divide result committed with none expected", $time);
      end else if (commit.div.valid) begin
        exp_wb = div_q.pop_front();
        check_value("commit.div", (CMP_W)'(exp_wb), (CMP_W)'(commit.div));
      end
    end
    // No issue may be taken while the commit side stalls
    if (nRST && stall_commit) begin
      check_value("issue_ready", '0, (CMP_W)'(issue_ready));
    end
    last_commit = commit;
    was_flush = flush;
    was_stall = stall_commit;
    if (flush || stall_commit) begin
      held_edges++;
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [4:0]  opc;
    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;
    // Shift amounts 31 and 0, negative rs1
    for (int k = exec_pkg::OP_ADD; k <= exec_pkg::OP_SRA; k++) begin
      send(exec_pkg::exec_op_e'(k[4:0]), 32'h8000_00f0, 32'd31, 32'd0);
      send(exec_pkg::exec_op_e'(k[4:0]), 32'hffff_ff00, 32'h0000_0020, 32'd0);
    end
    for (int k = exec_pkg::OP_BEQ; k <= exec_pkg::OP_JALR; k++) begin
      send(exec_pkg::exec_op_e'(k[4:0]), 32'd77, 32'd77, 32'h0000_0104);
      send(exec_pkg::exec_op_e'(k[4:0]), 32'hffff_fff3, 32'd5, 32'hffff_fff8);
    end
    send(exec_pkg::OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 32'd0);
    send(exec_pkg::OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 32'd0);
    send(exec_pkg::OP_MUL, 32'h1234_5678, 32'h9abc_def0, 32'd0);
    send(exec_pkg::OP_MULHU, 32'h1234_5678, 32'h9abc_def0, 32'd0);
    // Zero divisor, then a divide that must wait for the first
    send(exec_pkg::OP_DIVU, 32'd1000, 32'd0, 32'd0);
    send(exec_pkg::OP_REMU, 32'd1000, 32'd0, 32'd0);
    send(exec_pkg::OP_DIVU, 32'hffff_fff0, 32'd7, 32'd0);
    send(exec_pkg::OP_REMU, 32'hffff_fff0, 32'd7, 32'd0);
    send(exec_pkg::OP_MUL, 32'd12345, 32'd678, 32'd0);
    send(exec_pkg::OP_DIVU, 32'd99999, 32'd13, 32'd0);
    hold_commit(6);
    send(exec_pkg::OP_ADD, 32'd1, 32'd2, 32'd0);
    send(exec_pkg::OP_REMU, 32'd5000, 32'd7, 32'd0);
    send(exec_pkg::OP_MULHU, 32'h8000_0000, 32'h0000_0003, 32'd0);
    flush_pipe();
    send(exec_pkg::OP_SUB, 32'd3, 32'd9, 32'd0);
    for (int n = 0; n < N_RANDOM; n++) begin
      r = lcg_next();
      if (r[27:24] == 4'd0) begin
        hold_commit(1 + r[21:20]);
      end
      if (r[31:26] == 6'd1) begin
        flush_pipe();
      end
      opc = 5'd1 + 5'(r[15:8] % 8'd20);
      send(exec_pkg::exec_op_e'(opc), pick_operand(), pick_operand(), lcg_next());
    end
    while (arith_q.size() + mul_q.size() + div_q.size() + flow_q.size() != 0) begin
      @(posedge CLK);
    end
    repeat (5) @(posedge CLK);
    $display("%0d ops issued, %0d errors", n_issued, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* compile.f */
exec_pkg.sv
alu_branch_unit.sv
mul_pipe.sv
div_ctrl_fsm.sv
div_iter_counter.sv
div_datapath.sv
commit_latch.sv
execute_stage.sv
execute_stage_props.sv
tb_execute_stage.sv

/* Makefile */
TOP = tb_execute_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
